// File: design/trap_settings.svh
// Trap unit build constants
// Shared by the trap unit blocks and its testbench

`ifndef TRAP_SETTINGS_SVH
`define TRAP_SETTINGS_SVH

// Width of PCs, trap values and machine CSRs
`define TRAP_XLEN 32

// Records held between producer and consumer, power of two
`define TRAP_QUEUE_DEPTH 4

// Cycles the consumer stays busy after presenting a trap
`define TRAP_DRAIN_CYCLES 3

`endif

// File: design/trap_pkg.sv
// Trap unit types
// Privilege, cause and retire opcode encodings and the trap record
`default_nettype none
`include "trap_settings.svh"

package trap_pkg;

    typedef enum logic [1:0] {
        U_MODE = 2'd0,
        M_MODE = 2'd3
    } priv_mode_t;

    // Exception codes as written to mcause
    typedef enum logic [3:0] {
        INSN_MAL     = 4'd0,
        INSN_ACCESS  = 4'd1,
        ILLEGAL_INSN = 4'd2,
        BREAKPOINT   = 4'd3,
        L_ADDR_MAL   = 4'd4,
        L_FAULT      = 4'd5,
        S_ADDR_MAL   = 4'd6,
        S_FAULT      = 4'd7,
        ENV_CALL_U   = 4'd8,
        ENV_CALL_M   = 4'd11
    } ex_code_t;

    typedef enum logic [3:0] {
        SOFT_INT_M  = 4'd3,
        TIMER_INT_M = 4'd7,
        EXT_INT_M   = 4'd11
    } int_code_t;

    typedef enum logic [1:0] {
        OP_NORMAL,
        OP_ECALL,
        OP_MRET
    } retire_op_t;

    typedef struct packed {
        logic mal_insn;
        logic fault_insn;
        logic illegal_insn;
        logic breakpoint;
        logic mal_l;
        logic fault_l;
        logic mal_s;
        logic fault_s;
    } exc_flags_t;

    typedef struct packed {
        logic                  interrupt;  // Set for interrupts, clear for exceptions
        logic [3:0]            cause;
        logic [`TRAP_XLEN-1:0] epc;
        logic [`TRAP_XLEN-1:0] tval;
    } trap_rec_t;

endpackage

`default_nettype wire

// File: design/trap_if.sv
// Trap record handshake
// Valid/ready channel that moves one trap record per transfer
`timescale 1ns/1ns
`default_nettype none
`include "trap_settings.svh"

interface trap_if import trap_pkg::*; ();

    logic      valid;
    logic      ready;
    trap_rec_t rec;     // Held stable while valid waits for ready

    modport producer (
        output valid,
        output rec,
        input  ready
    );

    modport consumer (
        input  valid,
        input  rec,
        output ready
    );

endinterface

`default_nettype wire

// File: design/trap_handler.sv
// Machine-mode trap producer
// Holds pending interrupts, mstatus bits and the privilege mode, picks the
// trap cause of each retiring instruction and issues one record per trap
`timescale 1ns/1ns
`default_nettype none
`include "trap_settings.svh"

module trap_handler import trap_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        retire_valid,
    output logic                       retire_ready,
    input  wire  [`TRAP_XLEN-1:0]      retire_pc,
    input  wire  retire_op_t           retire_op,
    input  wire  exc_flags_t           retire_flags,
    input  wire  [`TRAP_XLEN-1:0]      bad_addr,
    input  wire                        irq_ext,
    input  wire                        irq_soft,
    input  wire                        irq_timer,
    input  wire                        clr_ext,
    input  wire                        clr_soft,
    input  wire                        clr_timer,
    input  wire  [2:0]                 int_enable,  // {ext, soft, timer}
    output logic                       status_mie,
    output priv_mode_t                 priv_mode,
    trap_if.producer                   issue
);

    logic       mpie;
    priv_mode_t mpp;
    logic [2:0] pend;        // {ext, soft, timer}
    logic [2:0] int_pend;
    logic       exception;
    logic       ex_tval_en;
    logic       interrupt_fired;
    logic       take_trap;
    logic       retire_fire;
    ex_code_t   ex_src;
    int_code_t  int_src;
    trap_rec_t  next_rec;

    // Output stage is free or draining this cycle
    assign retire_ready = issue.ready;
    assign retire_fire  = retire_valid && retire_ready;

    // Exception priority, ecall ranks between instruction and data faults
    always_comb begin
        exception  = 1'b1;
        ex_tval_en = 1'b1;
        ex_src     = INSN_MAL;
        if (retire_flags.breakpoint)
            ex_src = BREAKPOINT;
        else if (retire_flags.fault_insn)
            ex_src = INSN_ACCESS;
        else if (retire_flags.illegal_insn)
            ex_src = ILLEGAL_INSN;
        else if (retire_flags.mal_insn)
            ex_src = INSN_MAL;
        else if (retire_op == OP_ECALL) begin
            ex_src     = (priv_mode == M_MODE) ? ENV_CALL_M : ENV_CALL_U;
            ex_tval_en = 1'b0;
        end
        else if (retire_flags.mal_s)
            ex_src = S_ADDR_MAL;
        else if (retire_flags.mal_l)
            ex_src = L_ADDR_MAL;
        else if (retire_flags.fault_s)
            ex_src = S_FAULT;
        else if (retire_flags.fault_l)
            ex_src = L_FAULT;
        else begin
            exception  = 1'b0;
            ex_tval_en = 1'b0;
        end
    end

    assign int_pend        = pend & int_enable;
    assign interrupt_fired = status_mie && (int_pend != 3'b000);
    assign take_trap       = exception || interrupt_fired;

    always_comb begin
        if (int_pend[2])
            int_src = EXT_INT_M;
        else if (int_pend[1])
            int_src = SOFT_INT_M;
        else
            int_src = TIMER_INT_M;
    end

    always_comb begin
        next_rec.interrupt = !exception;  // Exception on the same retire wins
        next_rec.cause     = exception ? 4'(ex_src) : 4'(int_src);
        next_rec.epc       = retire_pc;
        next_rec.tval      = (exception && ex_tval_en) ? bad_addr : '0;
    end

    // Pending bits, set wins over clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pend <= 3'b000;
        else
            pend <= (pend & ~{clr_ext, clr_soft, clr_timer}) | {irq_ext, irq_soft, irq_timer};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_mie <= 1'b0;
            mpie       <= 1'b0;
            mpp        <= U_MODE;
            priv_mode  <= M_MODE;
        end else if (retire_fire) begin
            if (take_trap) begin
                mpie       <= status_mie;
                status_mie <= 1'b0;
                mpp        <= priv_mode;
                priv_mode  <= M_MODE;
            end else if (retire_op == OP_MRET) begin
                status_mie <= mpie;
                mpie       <= 1'b1;
                priv_mode  <= mpp;
                mpp        <= U_MODE;  // Drop back to the least privileged mode
            end
        end
    end

    // One-entry output stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            issue.valid <= 1'b0;
        else if (retire_fire && take_trap)
            issue.valid <= 1'b1;
        else if (issue.ready)
            issue.valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (retire_fire && take_trap)
            issue.rec <= next_rec;
    end

endmodule

`default_nettype wire

// File: design/trap_queue.sv
// Trap record FIFO
// Circular buffer between the trap producer and the commit stage,
// push and pop may happen in the same cycle
`timescale 1ns/1ns
`default_nettype none
`include "trap_settings.svh"

module trap_queue import trap_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    trap_if.consumer   push_side,
    trap_if.producer   pop_side
);

    localparam int DEPTH = `TRAP_QUEUE_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    trap_rec_t     mem [DEPTH];
    logic [AW:0]   wr_ptr;     // Extra bit tells full from empty
    logic [AW:0]   rd_ptr;
    logic          full;
    logic          empty;
    logic          push;
    logic          pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign push_side.ready = !full;
    assign pop_side.valid  = !empty;
    assign pop_side.rec    = mem[rd_ptr[AW-1:0]];  // Head of queue

    assign push = push_side.valid && push_side.ready;
    assign pop  = pop_side.valid && pop_side.ready;

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr[AW-1:0]] <= push_side.rec;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/trap_commit.sv
// Trap commit stage
// Takes one record at a time, latches mcause/mepc/mtval, presents the trap
// for a cycle with its redirect target, then drains like a pipeline flush
`timescale 1ns/1ns
`default_nettype none
`include "trap_settings.svh"

module trap_commit import trap_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire  [`TRAP_XLEN-1:0]      mtvec,
    trap_if.consumer                   take,
    output logic                       trap_valid,
    output logic                       trap_interrupt,
    output logic [3:0]                 trap_cause,
    output logic [`TRAP_XLEN-1:0]      trap_epc,
    output logic [`TRAP_XLEN-1:0]      trap_tval,
    output logic [`TRAP_XLEN-1:0]      redirect_pc,
    output logic [`TRAP_XLEN-1:0]      mcause,
    output logic [`TRAP_XLEN-1:0]      mepc,
    output logic [`TRAP_XLEN-1:0]      mtval
);

    localparam int XLEN = `TRAP_XLEN;
    localparam int CW   = $clog2(`TRAP_DRAIN_CYCLES + 1);

    typedef enum logic [1:0] {
        IDLE,
        PRESENT,
        DRAIN
    } state_t;

    state_t          state;
    logic [CW-1:0]   drain_cnt;
    trap_rec_t       rec;
    logic            fire;
    logic [XLEN-1:0] tvec_base;
    logic [XLEN-1:0] target;

    assign rec        = take.rec;
    assign take.ready = (state == IDLE);
    assign fire       = take.valid && take.ready;

    // Vectored mode only applies to interrupts
    assign tvec_base = {mtvec[XLEN-1:2], 2'b00};
    assign target    = (rec.interrupt && mtvec[0]) ?
                       tvec_base + XLEN'({rec.cause, 2'b00}) : tvec_base;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            drain_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (fire)
                        state <= PRESENT;
                end
                PRESENT: begin
                    state     <= DRAIN;
                    drain_cnt <= CW'(`TRAP_DRAIN_CYCLES - 1);
                end
                DRAIN: begin
                    if (drain_cnt == '0)
                        state <= IDLE;
                    else
                        drain_cnt <= drain_cnt - 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Machine CSRs, interrupt flag sits in the top bit of mcause
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcause <= '0;
            mepc   <= '0;
            mtval  <= '0;
        end else if (fire) begin
            mcause <= {rec.interrupt, {(XLEN - 5){1'b0}}, rec.cause};
            mepc   <= rec.epc;
            mtval  <= rec.tval;
        end
    end

    always_ff @(posedge clk) begin
        if (fire)
            redirect_pc <= target;
    end

    assign trap_valid     = (state == PRESENT);  // One cycle per trap
    assign trap_interrupt = mcause[XLEN-1];
    assign trap_cause     = mcause[3:0];
    assign trap_epc       = mepc;
    assign trap_tval      = mtval;

endmodule

`default_nettype wire

// File: design/trap_unit.sv
// Machine-mode trap unit top
// Producer, record FIFO and commit stage joined by two trap record channels
`timescale 1ns/1ns
`default_nettype none
`include "trap_settings.svh"

module trap_unit import trap_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        retire_valid,
    output logic                       retire_ready,
    input  wire  [`TRAP_XLEN-1:0]      retire_pc,
    input  wire  retire_op_t           retire_op,
    input  wire  exc_flags_t           retire_flags,
    input  wire  [`TRAP_XLEN-1:0]      bad_addr,
    input  wire                        irq_ext,
    input  wire                        irq_soft,
    input  wire                        irq_timer,
    input  wire                        clr_ext,
    input  wire                        clr_soft,
    input  wire                        clr_timer,
    input  wire  [2:0]                 int_enable,
    input  wire  [`TRAP_XLEN-1:0]      mtvec,
    output logic                       status_mie,
    output priv_mode_t                 priv_mode,
    output logic                       trap_valid,
    output logic                       trap_interrupt,
    output logic [3:0]                 trap_cause,
    output logic [`TRAP_XLEN-1:0]      trap_epc,
    output logic [`TRAP_XLEN-1:0]      trap_tval,
    output logic [`TRAP_XLEN-1:0]      redirect_pc,
    output logic [`TRAP_XLEN-1:0]      mcause,
    output logic [`TRAP_XLEN-1:0]      mepc,
    output logic [`TRAP_XLEN-1:0]      mtval
);

    trap_if issue_bus ();   // Producer to FIFO
    trap_if commit_bus ();  // FIFO to commit stage

    trap_handler u_handler (
        .clk          (clk),
        .rst_n        (rst_n),
        .retire_valid (retire_valid),
        .retire_ready (retire_ready),
        .retire_pc    (retire_pc),
        .retire_op    (retire_op),
        .retire_flags (retire_flags),
        .bad_addr     (bad_addr),
        .irq_ext      (irq_ext),
        .irq_soft     (irq_soft),
        .irq_timer    (irq_timer),
        .clr_ext      (clr_ext),
        .clr_soft     (clr_soft),
        .clr_timer    (clr_timer),
        .int_enable   (int_enable),
        .status_mie   (status_mie),
        .priv_mode    (priv_mode),
        .issue        (issue_bus.producer)
    );

    trap_queue u_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push_side (issue_bus.consumer),
        .pop_side  (commit_bus.producer)
    );

    trap_commit u_commit (
        .clk            (clk),
        .rst_n          (rst_n),
        .mtvec          (mtvec),
        .take           (commit_bus.consumer),
        .trap_valid     (trap_valid),
        .trap_interrupt (trap_interrupt),
        .trap_cause     (trap_cause),
        .trap_epc       (trap_epc),
        .trap_tval      (trap_tval),
        .redirect_pc    (redirect_pc),
        .mcause         (mcause),
        .mepc           (mepc),
        .mtval          (mtval)
    );

endmodule

`default_nettype wire

// File: verification/trap_unit_tb.sv
// Trap unit testbench
// LFSR driven retire and interrupt traffic, checked against a reference
// model of the trap, status, pending and redirect rules
`timescale 1ns/1ns
`default_nettype none
`include "trap_settings.svh"

module trap_unit_tb import trap_pkg::*; ();

    localparam int XLEN            = `TRAP_XLEN;
    localparam int DEPTH           = `TRAP_QUEUE_DEPTH;
    localparam int DRAIN           = `TRAP_DRAIN_CYCLES;
    localparam int RESET_CYCLES    = 8;
    localparam int STIM_CYCLES     = 2000;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + STIM_CYCLES + 2 * DRAIN * DEPTH + 100;
    localparam int FLUSH_CYCLES    = (DEPTH + 3) * (DRAIN + 2);  // Enough to empty every stage
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

    logic            clk;
    logic            rst_n;
    logic            retire_valid;
    logic            retire_ready;
    logic [XLEN-1:0] retire_pc;
    retire_op_t      retire_op;
    exc_flags_t      retire_flags;
    logic [XLEN-1:0] bad_addr;
    logic            irq_ext;
    logic            irq_soft;
    logic            irq_timer;
    logic            clr_ext;
    logic            clr_soft;
    logic            clr_timer;
    logic [2:0]      int_enable;
    logic [XLEN-1:0] mtvec;
    logic            status_mie;
    priv_mode_t      priv_mode;
    logic            trap_valid;
    logic            trap_interrupt;
    logic [3:0]      trap_cause;
    logic [XLEN-1:0] trap_epc;
    logic [XLEN-1:0] trap_tval;
    logic [XLEN-1:0] redirect_pc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mtval;

    logic [31:0]     lfsr;
    logic            m_mie;         // Reference model state
    logic            m_mpie;
    priv_mode_t      m_mpp;
    priv_mode_t      m_mode;
    logic [2:0]      m_pend;        // {ext, soft, timer}
    logic [XLEN-1:0] prev_mtvec;    // mtvec seen when the commit stage took a record
    trap_rec_t       exp_q [$];
    int              cycle;
    int              flush_wait;

    trap_unit trap_unit_i (
        .clk(clk), .rst_n(rst_n),
        .retire_valid(retire_valid), .retire_ready(retire_ready),
        .retire_pc(retire_pc), .retire_op(retire_op),
        .retire_flags(retire_flags), .bad_addr(bad_addr),
        .irq_ext(irq_ext), .irq_soft(irq_soft), .irq_timer(irq_timer),
        .clr_ext(clr_ext), .clr_soft(clr_soft), .clr_timer(clr_timer),
        .int_enable(int_enable), .mtvec(mtvec),
        .status_mie(status_mie), .priv_mode(priv_mode),
        .trap_valid(trap_valid), .trap_interrupt(trap_interrupt),
        .trap_cause(trap_cause), .trap_epc(trap_epc), .trap_tval(trap_tval),
        .redirect_pc(redirect_pc), .mcause(mcause), .mepc(mepc), .mtval(mtval)
    );

    always #50 clk = ~clk;

    // Galois LFSR stepped once per bit handed out
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        b;
        int          i;
        val = '0;
        for (i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b)
                lfsr = lfsr ^ LFSR_TAPS;
            val = {val[30:0], b};
        end
        return val;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else stop_on_error($sformatf("Fail at %0t ns: %s is %h, expected %h",
                                     $time, name, got, exp));
    endtask

    // Trap rules applied to one accepted retire
    task automatic model_retire();
        trap_rec_t  rec;
        logic       is_exc;
        logic       tval_on;
        logic [2:0] live;
        is_exc  = 1'b1;
        tval_on = 1'b1;
        rec     = '0;
        if (retire_flags.breakpoint)        rec.cause = BREAKPOINT;
        else if (retire_flags.fault_insn)   rec.cause = INSN_ACCESS;
        else if (retire_flags.illegal_insn) rec.cause = ILLEGAL_INSN;
        else if (retire_flags.mal_insn)     rec.cause = INSN_MAL;
        else if (retire_op == OP_ECALL) begin
            rec.cause = (m_mode == M_MODE) ? ENV_CALL_M : ENV_CALL_U;
            tval_on   = 1'b0;
        end
        else if (retire_flags.mal_s)        rec.cause = S_ADDR_MAL;
        else if (retire_flags.mal_l)        rec.cause = L_ADDR_MAL;
        else if (retire_flags.fault_s)      rec.cause = S_FAULT;
        else if (retire_flags.fault_l)      rec.cause = L_FAULT;
        else
            is_exc = 1'b0;
        live = m_pend & int_enable;
        if (is_exc || (m_mie && live != 3'b000)) begin
            rec.interrupt = !is_exc;
            if (!is_exc)
                rec.cause = live[2] ? EXT_INT_M : (live[1] ? SOFT_INT_M : TIMER_INT_M);
            rec.epc  = retire_pc;
            rec.tval = (is_exc && tval_on) ? bad_addr : '0;
            exp_q.push_back(rec);
            m_mpie = m_mie;
            m_mie  = 1'b0;
            m_mpp  = m_mode;
            m_mode = M_MODE;
        end else if (retire_op == OP_MRET) begin
            m_mie  = m_mpie;
            m_mpie = 1'b1;
            m_mode = m_mpp;
            m_mpp  = U_MODE;
        end
    endtask

    // New retire only once the previous one was taken
    task automatic drive_random();
        logic [7:0] fbits;
        logic [3:0] op_pick;
        int         i;
        if (!(retire_valid && !retire_ready)) begin
            retire_valid <= (take_bits(5) < 19);  // About 60 %
            retire_pc    <= take_bits(30) << 2;
            bad_addr     <= take_bits(32);
            for (i = 0; i < 8; i++)
                fbits[i] = (take_bits(4) == 0);
            retire_flags <= fbits;
            op_pick = 4'(take_bits(4));
            if (op_pick == 4'd0)
                retire_op <= OP_ECALL;
            else if (op_pick == 4'd1)
                retire_op <= OP_MRET;
            else
                retire_op <= OP_NORMAL;
        end
        irq_ext   <= (take_bits(6) == 0);
        irq_soft  <= (take_bits(6) == 0);
        irq_timer <= (take_bits(6) == 0);
        clr_ext   <= (take_bits(5) == 0);
        clr_soft  <= (take_bits(5) == 0);
        clr_timer <= (take_bits(5) == 0);
    endtask

    // Compare each presented trap and track the model on pre-edge values
    always @(posedge clk) begin : monitor
        trap_rec_t       e;
        logic [XLEN-1:0] base;
        logic [XLEN-1:0] target;
        if (rst_n) begin
            check_value("status_mie", 32'(status_mie), 32'(m_mie));
            check_value("priv_mode", 32'(priv_mode), 32'(m_mode));
            assert (retire_ready || exp_q.size() >= DEPTH)
            else stop_on_error("retire_ready dropped while the trap queue was not backed up");
            if (trap_valid) begin
                assert (exp_q.size() != 0)
                else stop_on_error("trap presented with no expected trap pending");
                e      = exp_q.pop_front();
                base   = {prev_mtvec[XLEN-1:2], 2'b00};
                target = (e.interrupt && prev_mtvec[0]) ? base + (32'(e.cause) << 2) : base;
                check_value("trap_interrupt", 32'(trap_interrupt), 32'(e.interrupt));
                check_value("trap_cause", 32'(trap_cause), 32'(e.cause));
                check_value("trap_epc", trap_epc, e.epc);
                check_value("trap_tval", trap_tval, e.tval);
                check_value("mcause", mcause, {e.interrupt, 27'b0, e.cause});
                check_value("mepc", mepc, e.epc);
                check_value("mtval", mtval, e.tval);
                check_value("redirect_pc", redirect_pc, target);
            end
            if (retire_valid && retire_ready)
                model_retire();
            m_pend = (m_pend & ~{clr_ext, clr_soft, clr_timer}) | {irq_ext, irq_soft, irq_timer};
            prev_mtvec = mtvec;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_error("simulation did not finish");
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        retire_valid = 1'b0;
        retire_pc    = '0;
        retire_op    = OP_NORMAL;
        retire_flags = '0;
        bad_addr     = '0;
        {irq_ext, irq_soft, irq_timer} = 3'b000;
        {clr_ext, clr_soft, clr_timer} = 3'b000;
        int_enable   = 3'b000;
        lfsr         = 32'd31;
        m_mie        = 1'b0;
        m_mpie       = 1'b0;
        m_mpp        = U_MODE;
        m_mode       = M_MODE;
        m_pend       = 3'b000;
        prev_mtvec   = '0;
        mtvec        = take_bits(30) << 2;  // Direct mode first
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("retire_ready", 32'(retire_ready), 32'd1);
        check_value("trap_valid", 32'(trap_valid), 32'd0);
        check_value("mcause", mcause, '0);
        check_value("mepc", mepc, '0);
        check_value("mtval", mtval, '0);
        for (cycle = 0; cycle < STIM_CYCLES; cycle++) begin
            @(posedge clk);
            if (cycle % 256 == 0)
                int_enable <= 3'(take_bits(3));
            if (cycle == STIM_CYCLES / 2)
                mtvec <= (take_bits(30) << 2) | 32'd1;  // Vectored from here on
            drive_random();
        end
        @(posedge clk);
        while (retire_valid && !retire_ready)
            @(posedge clk);
        retire_valid <= 1'b0;
        {irq_ext, irq_soft, irq_timer} <= 3'b000;
        {clr_ext, clr_soft, clr_timer} <= 3'b000;
        flush_wait = 0;
        while (exp_q.size() != 0 && flush_wait < FLUSH_CYCLES) begin
            @(negedge clk);
            flush_wait++;
        end
        repeat (4 * (DRAIN + 2)) @(negedge clk);  // Catch any late extra trap
        if (exp_q.size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stop_on_error($sformatf("%0d expected traps never appeared", exp_q.size()));
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+design
design/trap_pkg.sv
design/trap_if.sv
design/trap_handler.sv
design/trap_queue.sv
design/trap_commit.sv
design/trap_unit.sv
verification/trap_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the trap unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module trap_unit_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtrap_unit_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation passed"
exit 0
